//--- hdl/mips_mem_params.svh
`ifndef MIPS_MEM_PARAMS_SVH
`define MIPS_MEM_PARAMS_SVH

// Data path and address width
`define MIPS_NBITS 32

// Register index width
`define MIPS_REGS 5

// Data memory depth, log2 of the word count
`define MIPS_MEM_WORDS_LOG2 8

`endif

//--- hdl/mips_mem_pkg.sv
`include "mips_mem_params.svh"

package mips_mem_pkg;

    // Shared by store and load filters
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_t;

    typedef struct packed {
        logic [`MIPS_NBITS-1:0] pc8;
        logic [`MIPS_NBITS-1:0] pc_branch;
        logic                   zero;
        logic [`MIPS_NBITS-1:0] alu;
        logic [`MIPS_NBITS-1:0] rt_data;
        logic [`MIPS_REGS-1:0]  dest_reg;
        logic [`MIPS_NBITS-1:0] imm_ext;
        // Memory stage controls
        logic                   branch;
        logic                   nbranch;
        logic                   mem_write;
        logic                   mem_read;
        access_size_t           store_size;
        // Write-back controls
        logic                   jal;
        logic                   mem_to_reg;
        logic                   reg_write;
        access_size_t           load_size;
        logic                   zero_extend;
        logic                   lui;
    } ex_mem_t;

    typedef struct packed {
        logic [`MIPS_NBITS-1:0] rdata;
        logic [`MIPS_NBITS-1:0] alu;
        logic [`MIPS_NBITS-1:0] pc8;
        logic [`MIPS_NBITS-1:0] imm_ext;
        logic [1:0]             byte_off;
        logic [`MIPS_REGS-1:0]  dest_reg;
        logic                   jal;
        logic                   mem_to_reg;
        logic                   reg_write;
        access_size_t           load_size;
        logic                   zero_extend;
        logic                   lui;
    } mem_wb_t;

endpackage

//--- hdl/pipe_stage_reg.sv
`timescale 1ns/10ps

module pipe_stage_reg
#(
    parameter type payload_t = logic [31:0]
)
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_flush,
    input  payload_t i_data,
    output payload_t o_data
);

    // Squashed stage becomes a bubble with all controls low
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)
        begin
            o_data <= '0;
        end
        else
        begin
            o_data <= i_data;
        end
    end

    // Hazard unit stays quiet until reset is released
    assert property (@(posedge i_clk) !i_rst_n |-> !i_flush)
        else $error("flush raised during reset");

endmodule

//--- hdl/data_memory.sv
`timescale 1ns/10ps
`include "mips_mem_params.svh"

module data_memory
#(
    parameter int DATA_W = `MIPS_NBITS,
    parameter int ADDR_W = `MIPS_MEM_WORDS_LOG2
)
(
    input  logic              i_clk,
    input  logic              i_we,
    input  logic [3:0]        i_byte_en,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_wdata,
    output logic [DATA_W-1:0] o_rdata
);

    localparam int DEPTH = 2 ** ADDR_W;
    localparam int LANES = DATA_W / 8;

    logic [DATA_W-1:0] mem [0:DEPTH-1];

    // Each enabled lane is written independently
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            for (int lane = 0; lane < LANES; lane++)
            begin
                if (i_byte_en[lane])
                begin
                    mem[i_addr][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Asynchronous read, so a load resolves within the memory stage
    assign o_rdata = mem[i_addr];

    // The stage never issues a write that touches no lane
    assert property (@(posedge i_clk) i_we |-> (i_byte_en != 4'b0000))
        else $error("write with empty byte enables");

endmodule

//--- hdl/mem_access_stage.sv
`timescale 1ns/10ps
`include "mips_mem_params.svh"

module mem_access_stage
(
    input  logic                   i_clk,
    input  mips_mem_pkg::ex_mem_t  i_ex_mem,
    output mips_mem_pkg::mem_wb_t  o_mem_wb,
    output logic                   o_pc_src,
    output logic [`MIPS_NBITS-1:0] o_pc_branch
);

    localparam int AW = `MIPS_MEM_WORDS_LOG2;

    logic [1:0]             byte_off;
    logic [AW-1:0]          word_addr;
    logic [3:0]             byte_en;
    logic [`MIPS_NBITS-1:0] wdata;
    logic [`MIPS_NBITS-1:0] rdata;

    assign byte_off  = i_ex_mem.alu[1:0];
    assign word_addr = i_ex_mem.alu[AW+1:2];

    // beq on zero, bne on nonzero
    assign o_pc_src    = (i_ex_mem.branch & i_ex_mem.zero) | (i_ex_mem.nbranch & ~i_ex_mem.zero);
    assign o_pc_branch = i_ex_mem.pc_branch;

    // Replicate store data so every lane sees its own copy
    always_comb
    begin
        case (i_ex_mem.store_size)
            mips_mem_pkg::SIZE_BYTE:
            begin
                wdata   = {4{i_ex_mem.rt_data[7:0]}};
                byte_en = 4'b0001 << byte_off;
            end
            mips_mem_pkg::SIZE_HALF:
            begin
                wdata   = {2{i_ex_mem.rt_data[15:0]}};
                byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                wdata   = i_ex_mem.rt_data;
                byte_en = 4'b1111;
            end
        endcase
    end

    data_memory data_memory_inst (
        .i_clk     (i_clk),
        .i_we      (i_ex_mem.mem_write),
        .i_byte_en (byte_en),
        .i_addr    (word_addr),
        .i_wdata   (wdata),
        .o_rdata   (rdata)
    );

    always_comb
    begin
        o_mem_wb.rdata       = i_ex_mem.mem_read ? rdata : '0;
        o_mem_wb.alu         = i_ex_mem.alu;
        o_mem_wb.pc8         = i_ex_mem.pc8;
        o_mem_wb.imm_ext     = i_ex_mem.imm_ext;
        o_mem_wb.byte_off    = byte_off;
        o_mem_wb.dest_reg    = i_ex_mem.dest_reg;
        o_mem_wb.jal         = i_ex_mem.jal;
        o_mem_wb.mem_to_reg  = i_ex_mem.mem_to_reg;
        o_mem_wb.reg_write   = i_ex_mem.reg_write;
        o_mem_wb.load_size   = i_ex_mem.load_size;
        o_mem_wb.zero_extend = i_ex_mem.zero_extend;
        o_mem_wb.lui         = i_ex_mem.lui;
    end

    // Decode only produces naturally aligned stores
    assert property (@(posedge i_clk)
        i_ex_mem.mem_write && i_ex_mem.store_size == mips_mem_pkg::SIZE_HALF |-> !byte_off[0])
        else $error("misaligned half store");
    assert property (@(posedge i_clk)
        i_ex_mem.mem_write && i_ex_mem.store_size == mips_mem_pkg::SIZE_WORD |-> byte_off == 2'b00)
        else $error("misaligned word store");

endmodule

//--- hdl/writeback_format.sv
`timescale 1ns/10ps
`include "mips_mem_params.svh"

module writeback_format
(
    input  mips_mem_pkg::mem_wb_t  i_mem_wb,
    output logic                   o_wb_en,
    output logic [`MIPS_REGS-1:0]  o_wb_reg,
    output logic [`MIPS_NBITS-1:0] o_wb_data
);

    logic [7:0]             byte_lane;
    logic [15:0]            half_lane;
    logic [`MIPS_NBITS-1:0] load_val;

    // Pick the addressed lane out of the read word
    always_comb
    begin
        case (i_mem_wb.byte_off)
            2'd0:    byte_lane = i_mem_wb.rdata[7:0];
            2'd1:    byte_lane = i_mem_wb.rdata[15:8];
            2'd2:    byte_lane = i_mem_wb.rdata[23:16];
            default: byte_lane = i_mem_wb.rdata[31:24];
        endcase
        half_lane = i_mem_wb.byte_off[1] ? i_mem_wb.rdata[31:16] : i_mem_wb.rdata[15:0];
    end

    // Sign or zero extension of sub-word loads
    always_comb
    begin
        case (i_mem_wb.load_size)
            mips_mem_pkg::SIZE_BYTE:
            begin
                if (i_mem_wb.zero_extend)
                    load_val = {24'b0, byte_lane};
                else
                    load_val = {{24{byte_lane[7]}}, byte_lane};
            end
            mips_mem_pkg::SIZE_HALF:
            begin
                if (i_mem_wb.zero_extend)
                    load_val = {16'b0, half_lane};
                else
                    load_val = {{16{half_lane[15]}}, half_lane};
            end
            default:
            begin
                load_val = i_mem_wb.rdata;
            end
        endcase
    end

    // jal beats lui beats load beats ALU
    always_comb
    begin
        if (i_mem_wb.jal)
            o_wb_data = i_mem_wb.pc8;
        else if (i_mem_wb.lui)
            o_wb_data = {i_mem_wb.imm_ext[15:0], 16'b0};
        else if (i_mem_wb.mem_to_reg)
            o_wb_data = load_val;
        else
            o_wb_data = i_mem_wb.alu;
    end

    assign o_wb_en  = i_mem_wb.reg_write;
    assign o_wb_reg = i_mem_wb.dest_reg;

endmodule

//--- hdl/mips_mem_wb_top.sv
`timescale 1ns/10ps
`include "mips_mem_params.svh"

module mips_mem_wb_top
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_flush,

    input  logic [`MIPS_NBITS-1:0] i_pc8,
    input  logic [`MIPS_NBITS-1:0] i_pc_branch,
    input  logic                   i_zero,
    input  logic [`MIPS_NBITS-1:0] i_alu,
    input  logic [`MIPS_NBITS-1:0] i_rt_data,
    input  logic [`MIPS_REGS-1:0]  i_dest_reg,
    input  logic [`MIPS_NBITS-1:0] i_imm_ext,

    input  logic                   i_branch,
    input  logic                   i_nbranch,
    input  logic                   i_mem_write,
    input  logic                   i_mem_read,
    input  logic [1:0]             i_store_size,

    input  logic                   i_jal,
    input  logic                   i_mem_to_reg,
    input  logic                   i_reg_write,
    input  logic [1:0]             i_load_size,
    input  logic                   i_zero_extend,
    input  logic                   i_lui,

    output logic                   o_pc_src,
    output logic [`MIPS_NBITS-1:0] o_pc_branch,
    output logic                   o_wb_en,
    output logic [`MIPS_REGS-1:0]  o_wb_reg,
    output logic [`MIPS_NBITS-1:0] o_wb_data
);

    mips_mem_pkg::ex_mem_t ex_mem_d;
    mips_mem_pkg::ex_mem_t ex_mem_q;
    mips_mem_pkg::mem_wb_t mem_wb_d;
    mips_mem_pkg::mem_wb_t mem_wb_q;

    // Gather the execute-stage results into one payload
    always_comb
    begin
        ex_mem_d.pc8         = i_pc8;
        ex_mem_d.pc_branch   = i_pc_branch;
        ex_mem_d.zero        = i_zero;
        ex_mem_d.alu         = i_alu;
        ex_mem_d.rt_data     = i_rt_data;
        ex_mem_d.dest_reg    = i_dest_reg;
        ex_mem_d.imm_ext     = i_imm_ext;
        ex_mem_d.branch      = i_branch;
        ex_mem_d.nbranch     = i_nbranch;
        ex_mem_d.mem_write   = i_mem_write;
        ex_mem_d.mem_read    = i_mem_read;
        ex_mem_d.store_size  = mips_mem_pkg::access_size_t'(i_store_size);
        ex_mem_d.jal         = i_jal;
        ex_mem_d.mem_to_reg  = i_mem_to_reg;
        ex_mem_d.reg_write   = i_reg_write;
        ex_mem_d.load_size   = mips_mem_pkg::access_size_t'(i_load_size);
        ex_mem_d.zero_extend = i_zero_extend;
        ex_mem_d.lui         = i_lui;
    end

    pipe_stage_reg #(.payload_t(mips_mem_pkg::ex_mem_t)) ex_mem_reg_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_data  (ex_mem_d),
        .o_data  (ex_mem_q)
    );

    mem_access_stage mem_access_stage_inst (
        .i_clk       (i_clk),
        .i_ex_mem    (ex_mem_q),
        .o_mem_wb    (mem_wb_d),
        .o_pc_src    (o_pc_src),
        .o_pc_branch (o_pc_branch)
    );

    // Nothing squashes an instruction once it has passed memory
    pipe_stage_reg #(.payload_t(mips_mem_pkg::mem_wb_t)) mem_wb_reg_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (1'b0),
        .i_data  (mem_wb_d),
        .o_data  (mem_wb_q)
    );

    writeback_format writeback_format_inst (
        .i_mem_wb  (mem_wb_q),
        .o_wb_en   (o_wb_en),
        .o_wb_reg  (o_wb_reg),
        .o_wb_data (o_wb_data)
    );

endmodule

//--- tb/tb_mips_mem_wb.sv
`timescale 1ns/10ps
`include "mips_mem_params.svh"

module tb_mips_mem_wb;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_flush;
    logic [`MIPS_NBITS-1:0] i_pc8;
    logic [`MIPS_NBITS-1:0] i_pc_branch;
    logic                   i_zero;
    logic [`MIPS_NBITS-1:0] i_alu;
    logic [`MIPS_NBITS-1:0] i_rt_data;
    logic [`MIPS_REGS-1:0]  i_dest_reg;
    logic [`MIPS_NBITS-1:0] i_imm_ext;
    logic                   i_branch;
    logic                   i_nbranch;
    logic                   i_mem_write;
    logic                   i_mem_read;
    logic [1:0]             i_store_size;
    logic                   i_jal;
    logic                   i_mem_to_reg;
    logic                   i_reg_write;
    logic [1:0]             i_load_size;
    logic                   i_zero_extend;
    logic                   i_lui;
    logic                   o_pc_src;
    logic [`MIPS_NBITS-1:0] o_pc_branch;
    logic                   o_wb_en;
    logic [`MIPS_REGS-1:0]  o_wb_reg;
    logic [`MIPS_NBITS-1:0] o_wb_data;

    // One queue per trace column
    int          tr_test[$];
    logic [31:0] tr_pad[$];
    logic [31:0] tr_ctrl[$];
    logic [31:0] tr_pc8[$];
    logic [31:0] tr_pcb[$];
    logic [31:0] tr_alu[$];
    logic [31:0] tr_rt[$];
    logic [31:0] tr_dest[$];
    logic [31:0] tr_imm[$];
    logic [31:0] tr_flags[$];
    logic [31:0] tr_exp_pcb[$];
    logic [31:0] tr_exp_reg[$];
    logic [31:0] tr_exp_data[$];

    integer seed;
    int     n_lines;
    int     pass_count;
    int     fail_count;
    int     test_fail;
    int     test_checks;
    bit     trace_ok;
    bit     trace_loaded;

    mips_mem_wb_top mips_mem_wb_top_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_pc8         (i_pc8),
        .i_pc_branch   (i_pc_branch),
        .i_zero        (i_zero),
        .i_alu         (i_alu),
        .i_rt_data     (i_rt_data),
        .i_dest_reg    (i_dest_reg),
        .i_imm_ext     (i_imm_ext),
        .i_branch      (i_branch),
        .i_nbranch     (i_nbranch),
        .i_mem_write   (i_mem_write),
        .i_mem_read    (i_mem_read),
        .i_store_size  (i_store_size),
        .i_jal         (i_jal),
        .i_mem_to_reg  (i_mem_to_reg),
        .i_reg_write   (i_reg_write),
        .i_load_size   (i_load_size),
        .i_zero_extend (i_zero_extend),
        .i_lui         (i_lui),
        .o_pc_src      (o_pc_src),
        .o_pc_branch   (o_pc_branch),
        .o_wb_en       (o_wb_en),
        .o_wb_reg      (o_wb_reg),
        .o_wb_data     (o_wb_data)
    );

    initial i_clk = 1'b0;

    always #5 i_clk = ~i_clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        test_checks++;
        if (actual !== expected)
        begin
            $display("Error at %t: %s is %h, expected %h", $time, name, actual, expected);
            fail_count++;
            test_fail++;
        end
        else
        begin
            pass_count++;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          rc;
        int          t;
        string       line;
        logic [31:0] f [0:11];
        trace_ok = 1'b0;
        fd = $fopen("tb/mem_wb_trace.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                rc = $fgets(line, fd);
                // Lines starting with a hash describe the columns
                if (rc > 0 && line.getc(0) != "#")
                begin
                    rc = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h", t,
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                 f[8], f[9], f[10], f[11]);
                    if (rc == 13)
                    begin
                        tr_test.push_back(t);
                        tr_pad.push_back(f[0]);
                        tr_ctrl.push_back(f[1]);
                        tr_pc8.push_back(f[2]);
                        tr_pcb.push_back(f[3]);
                        tr_alu.push_back(f[4]);
                        tr_rt.push_back(f[5]);
                        tr_dest.push_back(f[6]);
                        tr_imm.push_back(f[7]);
                        tr_flags.push_back(f[8]);
                        tr_exp_pcb.push_back(f[9]);
                        tr_exp_reg.push_back(f[10]);
                        tr_exp_data.push_back(f[11]);
                    end
                end
            end
            $fclose(fd);
            n_lines = tr_test.size();
            trace_ok = (n_lines > 0);
        end
    endtask

    task automatic drive_line(input int idx);
        logic [31:0] ctrl;
        logic [31:0] pad;
        logic [31:0] dest;
        logic [31:0] pc8;
        logic [31:0] pcb;
        logic [31:0] alu;
        logic [31:0] rt;
        logic [31:0] imm;
        ctrl = tr_ctrl[idx];
        pad  = tr_pad[idx];
        dest = tr_dest[idx];
        pc8  = tr_pc8[idx];
        pcb  = tr_pcb[idx];
        alu  = tr_alu[idx];
        rt   = tr_rt[idx];
        imm  = tr_imm[idx];
        // Fields that this line's result ignores get random filler
        if (pad[0])
            pc8 = $random(seed);
        if (pad[1])
            pcb = $random(seed);
        if (pad[2])
            alu = $random(seed);
        if (pad[3])
            rt = $random(seed);
        if (pad[4])
            imm = $random(seed);
        i_flush       <= ctrl[13];
        i_pc8         <= pc8;
        i_pc_branch   <= pcb;
        i_zero        <= ctrl[14];
        i_alu         <= alu;
        i_rt_data     <= rt;
        i_dest_reg    <= dest[4:0];
        i_imm_ext     <= imm;
        i_branch      <= ctrl[0];
        i_nbranch     <= ctrl[1];
        i_mem_write   <= ctrl[2];
        i_mem_read    <= ctrl[3];
        i_store_size  <= ctrl[5:4];
        i_jal         <= ctrl[6];
        i_mem_to_reg  <= ctrl[7];
        i_reg_write   <= ctrl[8];
        i_load_size   <= ctrl[10:9];
        i_zero_extend <= ctrl[11];
        i_lui         <= ctrl[12];
    endtask

    task automatic drive_idle();
        i_flush       <= 1'b0;
        i_pc8         <= '0;
        i_pc_branch   <= '0;
        i_zero        <= 1'b0;
        i_alu         <= '0;
        i_rt_data     <= '0;
        i_dest_reg    <= '0;
        i_imm_ext     <= '0;
        i_branch      <= 1'b0;
        i_nbranch     <= 1'b0;
        i_mem_write   <= 1'b0;
        i_mem_read    <= 1'b0;
        i_store_size  <= 2'b00;
        i_jal         <= 1'b0;
        i_mem_to_reg  <= 1'b0;
        i_reg_write   <= 1'b0;
        i_load_size   <= 2'b00;
        i_zero_extend <= 1'b0;
        i_lui         <= 1'b0;
    endtask

    // Flag bit 0 is the taken level, bit 1 asks for a target check
    task automatic check_branch(input int idx);
        logic [31:0] flags;
        flags = tr_flags[idx];
        check_value("o_pc_src", {31'b0, o_pc_src}, {31'b0, flags[0]});
        if (flags[1])
            check_value("o_pc_branch", o_pc_branch, tr_exp_pcb[idx]);
    endtask

    task automatic check_wb(input int idx);
        logic [31:0] flags;
        flags = tr_flags[idx];
        check_value("o_wb_en", {31'b0, o_wb_en}, {31'b0, flags[2]});
        if (flags[2])
        begin
            check_value("o_wb_reg", {27'b0, o_wb_reg}, tr_exp_reg[idx]);
            check_value("o_wb_data", o_wb_data, tr_exp_data[idx]);
        end
        // Write-back of the last line closes its test
        if (idx == n_lines - 1 || tr_test[idx + 1] != tr_test[idx])
        begin
            $display("Test %0d %s: %0d checks, %0d mismatches", tr_test[idx],
                     (test_fail == 0) ? "passed" : "failed", test_checks, test_fail);
            test_fail   = 0;
            test_checks = 0;
        end
    endtask

    initial
    begin
        seed        = 32'hbdcb;
        pass_count  = 0;
        fail_count  = 0;
        test_fail   = 0;
        test_checks = 0;
        $timeformat(-9, 1, " ns", 10);
        i_rst_n <= 1'b0;
        drive_idle();
        load_trace();
        if (!trace_ok)
        begin
            $display("The trace file tb/mem_wb_trace.txt could not be read or has no lines");
            $display("Something failed");
            $finish;
        end
        else
        begin
            trace_loaded = 1'b1;
            repeat (10) @(posedge i_clk);
            i_rst_n <= 1'b1;
            // Branch outputs settle one cycle after a line, write-back two
            for (int cyc = 0; cyc < n_lines + 2; cyc++)
            begin
                @(posedge i_clk);
                if (cyc < n_lines)
                    drive_line(cyc);
                else
                    drive_idle();
                @(negedge i_clk);
                if (cyc >= 2)
                    check_wb(cyc - 2);
                if (cyc >= 1 && cyc <= n_lines)
                    check_branch(cyc - 1);
            end
            $display("Summary: %0d checks passed, %0d checks failed", pass_count, fail_count);
            if (fail_count == 0)
                $display("Everything OK");
            else
                $display("Something failed");
            $finish;
        end
    end

    // Watchdog
    initial
    begin
        wait (trace_loaded);
        #((n_lines + 20) * 10);
        $display("Timeout: the trace did not complete within %0d clock cycles", n_lines + 20);
        $display("Something failed");
        $finish;
    end

endmodule

//--- tb/mem_wb_trace.txt
# test pad ctrl pc8 pc_branch alu rt_data dest imm flags exp_pc_branch exp_reg exp_data
# ctrl: 0 beq, 1 bne, 2 mem_write, 3 mem_read, 5:4 store size, 6 jal, 7 mem_to_reg,
#   8 reg_write, 10:9 load size, 11 zero_extend, 12 lui, 13 flush, 14 zero
# pad picks random pc8/pc_branch/alu/rt/imm, flags: 0 pc_src, 1 check target, 2 wb_en
1 13 0024 00000000 00000000 00000010 cafe1234 00 00000000 0 00000000 00 00000000
1 1b 0588 00000000 00000000 00000010 00000000 08 00000000 4 00000000 08 cafe1234
1 13 0024 00000000 00000000 00000014 0badf00d 00 00000000 0 00000000 00 00000000
1 1b 0588 00000000 00000000 00000014 00000000 09 00000000 4 00000000 09 0badf00d
2 13 0024 00000000 00000000 00000020 11223344 00 00000000 0 00000000 00 00000000
2 13 0004 00000000 00000000 00000021 555555aa 00 00000000 0 00000000 00 00000000
2 13 0004 00000000 00000000 00000023 000000bb 00 00000000 0 00000000 00 00000000
2 1b 0588 00000000 00000000 00000020 00000000 0a 00000000 4 00000000 0a bb22aa44
2 13 0014 00000000 00000000 00000022 9999ccdd 00 00000000 0 00000000 00 00000000
2 13 0004 00000000 00000000 00000020 123456ee 00 00000000 0 00000000 00 00000000
2 1b 0588 00000000 00000000 00000020 00000000 0b 00000000 4 00000000 0b ccddaaee
3 13 0024 00000000 00000000 00000030 8cf19ba5 00 00000000 0 00000000 00 00000000
3 1b 0188 00000000 00000000 00000030 00000000 01 00000000 4 00000000 01 ffffffa5
3 1b 0988 00000000 00000000 00000031 00000000 02 00000000 4 00000000 02 0000009b
3 1b 0188 00000000 00000000 00000031 00000000 03 00000000 4 00000000 03 ffffff9b
3 1b 0188 00000000 00000000 00000032 00000000 04 00000000 4 00000000 04 fffffff1
3 1b 0988 00000000 00000000 00000032 00000000 0a 00000000 4 00000000 0a 000000f1
3 1b 0988 00000000 00000000 00000033 00000000 05 00000000 4 00000000 05 0000008c
3 1b 0188 00000000 00000000 00000033 00000000 06 00000000 4 00000000 06 ffffff8c
3 1b 0988 00000000 00000000 00000030 00000000 07 00000000 4 00000000 07 000000a5
3 1b 0388 00000000 00000000 00000030 00000000 0c 00000000 4 00000000 0c ffff9ba5
3 1b 0b88 00000000 00000000 00000030 00000000 0d 00000000 4 00000000 0d 00009ba5
3 1b 0388 00000000 00000000 00000032 00000000 0e 00000000 4 00000000 0e ffff8cf1
3 1b 0b88 00000000 00000000 00000032 00000000 0f 00000000 4 00000000 0f 00008cf1
4 1d 4001 00000000 00400100 00000000 00000000 00 00000000 3 00400100 00 00000000
4 1f 0001 00000000 00000000 00000000 00000000 00 00000000 0 00000000 00 00000000
4 1d 0002 00000000 00400200 00000000 00000000 00 00000000 3 00400200 00 00000000
4 1f 4002 00000000 00000000 00000000 00000000 00 00000000 0 00000000 00 00000000
5 13 0024 00000000 00000000 00000040 5a5a5a5a 00 00000000 0 00000000 00 00000000
5 13 2024 00000000 00000000 00000040 ffffffff 00 00000000 0 00000000 00 00000000
5 1b 2100 00000000 00000000 12345678 00000000 14 00000000 0 00000000 00 00000000
5 1b 0588 00000000 00000000 00000040 00000000 15 00000000 4 00000000 15 5a5a5a5a
6 1e 0140 00400008 00000000 00000000 00000000 1f 00000000 4 00000000 1f 00400008
6 0f 1100 00000000 00000000 00000000 00000000 10 ffff8765 4 00000000 10 87650000
6 0f 1100 00000000 00000000 00000000 00000000 12 00001234 4 00000000 12 12340000
6 1b 0100 00000000 00000000 13579bdf 00000000 11 00000000 4 00000000 11 13579bdf

//--- mips_mem_wb.f
+incdir+hdl
hdl/mips_mem_pkg.sv
hdl/pipe_stage_reg.sv
hdl/data_memory.sv
hdl/mem_access_stage.sv
hdl/writeback_format.sv
hdl/mips_mem_wb_top.sv
tb/tb_mips_mem_wb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the MEM/WB testbench with Verilator, run it and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_mips_mem_wb

rm -rf obj_dir "$LOG"

# A failed build or a crashed run is recorded as a failure in the log
verilator --binary --assert -j 0 --top-module tb_mips_mem_wb -f mips_mem_wb.f -o "$BIN" \
    && ./obj_dir/"$BIN" 2>&1 | tee "$LOG" \
    || echo "Something failed" >> "$LOG"

[ -s "$LOG" ] || { echo "No simulation log was written"; exit 1; }

grep -q "Something failed" "$LOG" \
    && { echo "Simulation result: FAIL"; exit 1; } \
    || { echo "Simulation result: PASS"; exit 0; }
